// File: design/span_zbuf_macros.svh
`ifndef SPAN_ZBUF_MACROS_SVH
`define SPAN_ZBUF_MACROS_SVH

// pixels per memory burst, also the depth of every burst FIFO
`define SPAN_BURST 8

// FIFO pointer width, log2 of SPAN_BURST
`define SPAN_BURST_AW 3

// byte step between neighbouring pixels
`define SPAN_WORD_BYTES 4

`endif

// File: design/span_zbuf_pkg.sv
package span_zbuf_pkg;

    // unsigned depth value
    typedef logic [31:0] z_word_t;

    // packed RGBX pixel
    typedef logic [31:0] color_t;

    // byte address on the memory port
    typedef logic [31:0] addr_t;

    // sequencer phases, one burst goes RD_Z through WR_F
    typedef enum logic [2:0]
    {
        IDLE,
        RD_Z,
        RD_F,
        MERGE,
        WR_Z,
        WR_F,
        FINISH
    } span_state_t;

endpackage

// File: design/span_fifo.sv
`timescale 1ns/1ps
`include "span_zbuf_macros.svh"

module span_fifo
    import span_zbuf_pkg::*;
#(
    parameter type payload_t = z_word_t,
    parameter int  DEPTH     = `SPAN_BURST
)
(
    input  logic     rd_req,
    input  logic     arst_n,
    input  logic     push,
    input  payload_t wdata,
    input  logic     pop,
    output payload_t rdata,
    output logic     empty,
    output logic     full
);

    localparam int AW = `SPAN_BURST_AW;

    payload_t      mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_push;
    logic          do_pop;

    // overflow and underflow attempts are dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign empty = (count == '0);
    assign full  = (count == (AW + 1)'(DEPTH));

    // head entry always visible
    assign rdata = mem[rd_ptr];

    always_ff @(posedge rd_req)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge rd_req or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            if (do_push && !do_pop)
            begin
                count <= count + 1'b1;
            end
            else if (do_pop && !do_push)
            begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: design/span_interp.sv
`timescale 1ns/1ps

module span_interp
    import span_zbuf_pkg::*;
(
    input  logic        rd_req,
    input  logic        arst_n,
    input  logic        load,
    input  z_word_t     z1,
    input  z_word_t     slope,
    input  logic [31:0] rem,
    input  logic [31:0] err,
    input  logic [31:0] dx,
    input  logic        step,
    output z_word_t     z
);

    z_word_t     z_q;
    z_word_t     slope_q;
    logic [31:0] rem_q;
    logic [31:0] dx_q;
    logic [31:0] err_q;
    logic [32:0] err_sum;
    logic [31:0] err_next;
    logic        carry;

    // error term step, one extra bit so err + rem cannot wrap
    always_comb
    begin
        err_sum  = {1'b0, err_q} + {1'b0, rem_q};
        carry    = (err_sum >= {1'b0, dx_q});
        err_next = carry ? 32'(err_sum - {1'b0, dx_q}) : err_sum[31:0];
    end

    // span constants, held for the whole span
    always_ff @(posedge rd_req)
    begin
        if (load)
        begin
            slope_q <= slope;
            rem_q   <= rem;
            dx_q    <= dx;
        end
    end

    always_ff @(posedge rd_req or negedge arst_n)
    begin
        if (!arst_n)
        begin
            z_q   <= '0;
            err_q <= '0;
        end
        else if (load)
        begin
            z_q   <= z1;
            err_q <= err;
        end
        else if (step)
        begin
            // wraps at 32 bits
            z_q   <= z_q + slope_q + 32'(carry);
            err_q <= err_next;
        end
    end

    // z of the pixel about to be merged
    assign z = z_q;

endmodule

// File: design/depth_merge.sv
`timescale 1ns/1ps

module depth_merge
    import span_zbuf_pkg::*;
(
    input  logic    rd_req,
    input  logic    arst_n,
    input  logic    merge_go,
    input  z_word_t new_z,
    input  color_t  rgbx,
    input  z_word_t zin_data,
    input  logic    zin_empty,
    input  color_t  fin_data,
    input  logic    fin_empty,
    output logic    zin_pop,
    output logic    fin_pop,
    output logic    zout_push,
    output z_word_t zout_data,
    output logic    fout_push,
    output color_t  fout_data,
    output logic    pix_done
);

    color_t rgbx_q;
    logic   fire;
    logic   closer;

    // follows rgbx until merge_go rises, then holds through the merge
    always_ff @(posedge rd_req or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rgbx_q <= '0;
        end
        else if (!merge_go)
        begin
            rgbx_q <= rgbx;
        end
    end

    // one pixel per cycle once both stored words are present
    assign fire = merge_go && !zin_empty && !fin_empty;

    assign zin_pop   = fire;
    assign fin_pop   = fire;
    assign zout_push = fire;
    assign fout_push = fire;
    assign pix_done  = fire;

    // strict unsigned less-than
    assign closer = (new_z < zin_data);

    // losers write the stored pair back unchanged
    assign zout_data = closer ? new_z : zin_data;
    assign fout_data = closer ? rgbx_q : fin_data;

endmodule

// File: design/span_ctrl.sv
`timescale 1ns/1ps
`include "span_zbuf_macros.svh"

module span_ctrl
    import span_zbuf_pkg::*;
(
    input  logic        rd_req,
    input  logic        arst_n,
    input  logic        start,
    input  addr_t       fb_addr,
    input  addr_t       zbuff_addr,
    input  logic [31:0] dx,
    input  logic        mem_ack,
    input  logic        pix_done,
    output logic        mem_rd,
    output logic        mem_wr,
    output addr_t       mem_addr,
    output logic        zin_push,
    output logic        fin_push,
    output logic        zout_pop,
    output logic        fout_pop,
    output logic        fifo_sel,
    output logic        merge_go,
    output logic        load,
    output logic        busy,
    output logic        done
);

    localparam int AW = `SPAN_BURST_AW;

    span_state_t   state;
    logic [AW-1:0] beat_cnt;
    logic [31:0]   pix_base;
    logic [31:0]   remaining;
    logic [31:0]   burst_len;
    logic [31:0]   pix_idx;
    addr_t         fb_q;
    addr_t         zb_q;
    addr_t         base_addr;
    logic          accept;
    logic          advance;
    logic          last_beat;

    assign accept   = start && (state == IDLE);
    assign load     = accept;
    assign busy     = (state != IDLE);
    assign done     = (state == FINISH);
    assign mem_rd   = (state == RD_Z) || (state == RD_F);
    assign mem_wr   = (state == WR_Z) || (state == WR_F);
    assign merge_go = (state == MERGE);
    assign fifo_sel = (state == WR_F);

    // FIFO strobes follow the beats
    assign zin_push = (state == RD_Z) && mem_ack;
    assign fin_push = (state == RD_F) && mem_ack;
    assign zout_pop = (state == WR_Z) && mem_ack;
    assign fout_pop = (state == WR_F) && mem_ack;

    // short last burst
    assign burst_len = (remaining > 32'(`SPAN_BURST)) ? 32'(`SPAN_BURST) : remaining;
    assign last_beat = (32'(beat_cnt) == burst_len - 32'd1);

    // merge counts pixels, every other phase counts beats
    assign advance = merge_go ? pix_done : ((mem_rd || mem_wr) && mem_ack);

    assign pix_idx   = pix_base + 32'(beat_cnt);
    assign base_addr = ((state == RD_Z) || (state == WR_Z)) ? zb_q : fb_q;
    assign mem_addr  = base_addr + addr_t'(pix_idx * `SPAN_WORD_BYTES);

    always_ff @(posedge rd_req)
    begin
        if (accept)
        begin
            fb_q <= fb_addr;
            zb_q <= zbuff_addr;
        end
    end

    always_ff @(posedge rd_req or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state     <= IDLE;
            beat_cnt  <= '0;
            pix_base  <= '0;
            remaining <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (accept)
                    begin
                        beat_cnt  <= '0;
                        pix_base  <= '0;
                        remaining <= dx;
                        // empty span ends at once
                        state     <= (dx == '0) ? FINISH : RD_Z;
                    end
                end
                RD_Z, RD_F, MERGE, WR_Z, WR_F:
                begin
                    if (advance && !last_beat)
                    begin
                        beat_cnt <= beat_cnt + 1'b1;
                    end
                    else if (advance)
                    begin
                        beat_cnt <= '0;
                        case (state)
                            RD_Z:    state <= RD_F;
                            RD_F:    state <= MERGE;
                            MERGE:   state <= WR_Z;
                            WR_Z:    state <= WR_F;
                            default:
                            begin
                                // burst written back, move to the next one
                                pix_base  <= pix_base + burst_len;
                                remaining <= remaining - burst_len;
                                state     <= (remaining == burst_len) ? FINISH : RD_Z;
                            end
                        endcase
                    end
                end
                FINISH:
                begin
                    state <= IDLE;
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// File: design/span_zbuf_top.sv
`timescale 1ns/1ps
`include "span_zbuf_macros.svh"

module span_zbuf_top
    import span_zbuf_pkg::*;
(
    input  logic        rd_req,
    input  logic        arst_n,
    input  logic        start,
    input  addr_t       fb_addr,
    input  addr_t       zbuff_addr,
    input  logic [31:0] dx,
    input  z_word_t     z1,
    input  z_word_t     slope,
    input  logic [31:0] rem,
    input  logic [31:0] err,
    input  color_t      rgbx,
    output logic        mem_rd,
    output logic        mem_wr,
    output addr_t       mem_addr,
    output logic [31:0] mem_wdata,
    input  logic        mem_ack,
    input  logic [31:0] mem_rdata,
    output logic        busy,
    output logic        done
);

    logic    load;
    logic    pix_done;
    logic    merge_go;
    logic    fifo_sel;
    logic    zin_push;
    logic    fin_push;
    logic    zout_pop;
    logic    fout_pop;
    logic    zin_pop;
    logic    fin_pop;
    logic    zout_push;
    logic    fout_push;
    logic    zin_empty;
    logic    fin_empty;
    z_word_t z_cur;
    z_word_t zin_data;
    z_word_t zout_data;
    z_word_t zout_rdata;
    color_t  fin_data;
    color_t  fout_data;
    color_t  fout_rdata;

    // depth words go out first, then colour words
    assign mem_wdata = fifo_sel ? fout_rdata : zout_rdata;

    span_ctrl i_span_ctrl (
        .rd_req     (rd_req),
        .arst_n     (arst_n),
        .start      (start),
        .fb_addr    (fb_addr),
        .zbuff_addr (zbuff_addr),
        .dx         (dx),
        .mem_ack    (mem_ack),
        .pix_done   (pix_done),
        .mem_rd     (mem_rd),
        .mem_wr     (mem_wr),
        .mem_addr   (mem_addr),
        .zin_push   (zin_push),
        .fin_push   (fin_push),
        .zout_pop   (zout_pop),
        .fout_pop   (fout_pop),
        .fifo_sel   (fifo_sel),
        .merge_go   (merge_go),
        .load       (load),
        .busy       (busy),
        .done       (done)
    );

    span_interp i_span_interp (
        .rd_req (rd_req),
        .arst_n (arst_n),
        .load   (load),
        .z1     (z1),
        .slope  (slope),
        .rem    (rem),
        .err    (err),
        .dx     (dx),
        .step   (pix_done),
        .z      (z_cur)
    );

    depth_merge i_depth_merge (
        .rd_req    (rd_req),
        .arst_n    (arst_n),
        .merge_go  (merge_go),
        .new_z     (z_cur),
        .rgbx      (rgbx),
        .zin_data  (zin_data),
        .zin_empty (zin_empty),
        .fin_data  (fin_data),
        .fin_empty (fin_empty),
        .zin_pop   (zin_pop),
        .fin_pop   (fin_pop),
        .zout_push (zout_push),
        .zout_data (zout_data),
        .fout_push (fout_push),
        .fout_data (fout_data),
        .pix_done  (pix_done)
    );

    // stored depth burst from memory
    span_fifo #(.payload_t(z_word_t), .DEPTH(`SPAN_BURST)) i_z_in (
        .rd_req (rd_req),
        .arst_n (arst_n),
        .push   (zin_push),
        .wdata  (mem_rdata),
        .pop    (zin_pop),
        .rdata  (zin_data),
        .empty  (zin_empty),
        .full   ()
    );

    // stored colour burst from memory
    span_fifo #(.payload_t(color_t), .DEPTH(`SPAN_BURST)) i_f_in (
        .rd_req (rd_req),
        .arst_n (arst_n),
        .push   (fin_push),
        .wdata  (mem_rdata),
        .pop    (fin_pop),
        .rdata  (fin_data),
        .empty  (fin_empty),
        .full   ()
    );

    span_fifo #(.payload_t(z_word_t), .DEPTH(`SPAN_BURST)) i_z_out (
        .rd_req (rd_req),
        .arst_n (arst_n),
        .push   (zout_push),
        .wdata  (zout_data),
        .pop    (zout_pop),
        .rdata  (zout_rdata),
        .empty  (),
        .full   ()
    );

    span_fifo #(.payload_t(color_t), .DEPTH(`SPAN_BURST)) i_f_out (
        .rd_req (rd_req),
        .arst_n (arst_n),
        .push   (fout_push),
        .wdata  (fout_data),
        .pop    (fout_pop),
        .rdata  (fout_rdata),
        .empty  (),
        .full   ()
    );

endmodule

// File: tests/span_zbuf_scoreboard.sv
`timescale 1ns/1ps
`include "span_zbuf_macros.svh"

module span_zbuf_scoreboard
    import span_zbuf_pkg::*;
(
    input  logic        rd_req,
    input  logic        arst_n,
    input  logic        start,
    input  logic        busy,
    input  logic        done,
    input  addr_t       fb_addr,
    input  addr_t       zbuff_addr,
    input  logic [31:0] dx,
    input  z_word_t     z1,
    input  z_word_t     slope,
    input  logic [31:0] rem,
    input  logic [31:0] err,
    input  color_t      rgbx,
    input  logic        mem_rd,
    input  logic        mem_wr,
    input  logic        mem_ack,
    input  addr_t       mem_addr,
    input  logic [31:0] mem_rdata,
    input  logic [31:0] mem_wdata,
    output int          errors
);

    localparam int MAX_PIX = 64;

    z_word_t z_pred [MAX_PIX];
    z_word_t z_old  [MAX_PIX];
    color_t  f_old  [MAX_PIX];
    int      z_rd   [MAX_PIX];
    int      f_rd   [MAX_PIX];
    int      z_wr   [MAX_PIX];
    int      f_wr   [MAX_PIX];
    int      span_dx;
    addr_t   span_fb;
    addr_t   span_zb;
    color_t  span_rgbx;
    logic    active;
    longint  cyc;
    longint  last_wr_cyc;

    initial
    begin
        errors      = 0;
        active      = 1'b0;
        cyc         = 0;
        last_wr_cyc = 0;
        span_dx     = 0;
    end

    task automatic report_mismatch(string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        errors++;
    endtask

    // pixel index of a beat inside the region at base or -1 when outside
    function automatic int pixel_of(addr_t a, addr_t base);
        addr_t off;
        off = a - base;
        if (off >= addr_t'(span_dx * `SPAN_WORD_BYTES) || (off % `SPAN_WORD_BYTES) != 0)
        begin
            return -1;
        end
        return int'(off / `SPAN_WORD_BYTES);
    endfunction

    // depth words of the whole burst must be out before any colour word
    function automatic logic burst_depth_written(int idx);
        int first;
        int last;
        int j;
        first = (idx / `SPAN_BURST) * `SPAN_BURST;
        last  = first + `SPAN_BURST;
        if (last > span_dx)
        begin
            last = span_dx;
        end
        for (j = first; j < last; j++)
        begin
            if (z_wr[j] == 0)
            begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // z per pixel from slope plus the error-term carry
    task automatic predict_span();
        longint unsigned acc;
        z_word_t         zz;
        int              i;
        zz  = z1;
        acc = 64'(err);
        for (i = 0; i < span_dx && i < MAX_PIX; i++)
        begin
            if (i > 0)
            begin
                acc = acc + 64'(rem);
                if (acc >= 64'(dx))
                begin
                    acc = acc - 64'(dx);
                    zz  = zz + slope + 32'd1;
                end
                else
                begin
                    zz = zz + slope;
                end
            end
            z_pred[i] = zz;
            z_rd[i]   = 0;
            f_rd[i]   = 0;
            z_wr[i]   = 0;
            f_wr[i]   = 0;
        end
    endtask

    task automatic check_read();
        int zi;
        int fi;
        zi = pixel_of(mem_addr, span_zb);
        fi = pixel_of(mem_addr, span_fb);
        if (!active)
        begin
            report_mismatch($sformatf("read beat at %h outside a span", mem_addr));
        end
        else if (zi >= 0)
        begin
            z_old[zi] = mem_rdata;
            z_rd[zi]++;
        end
        else if (fi >= 0)
        begin
            f_old[fi] = mem_rdata;
            f_rd[fi]++;
        end
        else
        begin
            report_mismatch($sformatf("read beat at %h outside both buffers", mem_addr));
        end
    endtask

    task automatic check_write();
        int      zi;
        int      fi;
        z_word_t expect_z;
        color_t  expect_f;
        zi = pixel_of(mem_addr, span_zb);
        fi = pixel_of(mem_addr, span_fb);
        last_wr_cyc = cyc;
        if (!active)
        begin
            report_mismatch($sformatf("write beat at %h outside a span", mem_addr));
        end
        else if (zi >= 0)
        begin
            if (z_rd[zi] == 0 || f_rd[zi] == 0)
            begin
                report_mismatch($sformatf("depth pixel %0d written before it was read", zi));
            end
            expect_z = (z_pred[zi] < z_old[zi]) ? z_pred[zi] : z_old[zi];
            if (mem_wdata !== expect_z)
            begin
                report_mismatch($sformatf("depth pixel %0d got %h expected %h",
                                          zi, mem_wdata, expect_z));
            end
            z_wr[zi]++;
        end
        else if (fi >= 0)
        begin
            if (!burst_depth_written(fi))
            begin
                report_mismatch($sformatf("colour pixel %0d written before its depth burst", fi));
            end
            expect_f = (z_pred[fi] < z_old[fi]) ? span_rgbx : f_old[fi];
            if (mem_wdata !== expect_f)
            begin
                report_mismatch($sformatf("colour pixel %0d got %h expected %h",
                                          fi, mem_wdata, expect_f));
            end
            f_wr[fi]++;
        end
        else
        begin
            report_mismatch($sformatf("write beat at %h outside both buffers", mem_addr));
        end
    endtask

    task automatic check_span_end();
        int i;
        if (!active)
        begin
            report_mismatch("done pulse without an accepted start");
        end
        else
        begin
            if (cyc != last_wr_cyc + 1)
            begin
                report_mismatch("done is not one cycle after the last write beat");
            end
            for (i = 0; i < span_dx && i < MAX_PIX; i++)
            begin
                if (z_wr[i] != 1 || f_wr[i] != 1)
                begin
                    report_mismatch($sformatf("pixel %0d written %0d depth and %0d colour times",
                                              i, z_wr[i], f_wr[i]));
                end
            end
        end
        active = 1'b0;
    endtask

    // sampled mid-cycle so a beat seen here completes on the next rising edge
    always @(negedge rd_req)
    begin
        if (arst_n)
        begin
            cyc++;
            // busy is low in the start cycle and high until the done cycle ends
            if (busy !== active)
            begin
                report_mismatch($sformatf("busy is %b, expected %b", busy, active));
            end
            if (start && !active)
            begin
                span_dx   = int'(dx);
                span_fb   = fb_addr;
                span_zb   = zbuff_addr;
                span_rgbx = rgbx;
                predict_span();
                active = 1'b1;
            end
            if (mem_rd && mem_ack)
            begin
                check_read();
            end
            if (mem_wr && mem_ack)
            begin
                check_write();
            end
            if (done)
            begin
                check_span_end();
            end
        end
    end

endmodule

// File: tests/span_zbuf_chk.sv
`timescale 1ns/1ps

module span_zbuf_chk
    import span_zbuf_pkg::*;
(
    input logic  rd_req,
    input logic  arst_n,
    input logic  start,
    input logic  busy,
    input logic  load,
    input logic  done,
    input logic  mem_rd,
    input logic  mem_wr,
    input logic  mem_ack,
    input addr_t mem_addr
);

    int fail_cnt = 0;

    // one request direction at a time
    rd_wr_exclusive: assert property (@(posedge rd_req) disable iff (!arst_n)
        !(mem_rd && mem_wr))
    else
    begin
        $error("mem_rd and mem_wr are high in the same cycle");
        fail_cnt++;
    end

    done_single: assert property (@(posedge rd_req) disable iff (!arst_n)
        done |=> !done)
    else
    begin
        $error("done stayed high for more than one cycle");
        fail_cnt++;
    end

    // back-pressure freezes the request
    req_hold: assert property (@(posedge rd_req) disable iff (!arst_n)
        ((mem_rd || mem_wr) && !mem_ack)
            |=> ($stable(mem_rd) && $stable(mem_wr) && $stable(mem_addr)))
    else
    begin
        $error("request or mem_addr changed while mem_ack was low");
        fail_cnt++;
    end

    no_busy_start: assert property (@(posedge rd_req) disable iff (!arst_n)
        (start && busy) |-> !load)
    else
    begin
        $error("start was accepted while busy was high");
        fail_cnt++;
    end

endmodule

bind span_ctrl span_zbuf_chk i_span_zbuf_chk (
    .rd_req   (rd_req),
    .arst_n   (arst_n),
    .start    (start),
    .busy     (busy),
    .load     (load),
    .done     (done),
    .mem_rd   (mem_rd),
    .mem_wr   (mem_wr),
    .mem_ack  (mem_ack),
    .mem_addr (mem_addr)
);

// File: tests/span_zbuf_tb.sv
`timescale 1ns/1ps
`include "span_zbuf_macros.svh"

module span_zbuf_tb;
    import span_zbuf_pkg::*;

    localparam int NUM_SPANS = 7;

    typedef struct packed
    {
        logic [31:0] dx;
        z_word_t     z1;
        z_word_t     slope;
        logic [31:0] rem;
        logic [31:0] err;
        color_t      rgbx;
        addr_t       fb;
        addr_t       zb;
        logic [1:0]  zpat;
        logic        stall;
        logic        busy_start;
        logic [7:0]  exp_beats;
        logic [7:0]  ref_idx;
    } span_entry_t;

    logic        rd_req;
    logic        arst_n;
    logic        start;
    addr_t       fb_addr;
    addr_t       zbuff_addr;
    logic [31:0] dx;
    z_word_t     z1;
    z_word_t     slope;
    logic [31:0] rem;
    logic [31:0] err;
    color_t      rgbx;
    logic        mem_rd;
    logic        mem_wr;
    addr_t       mem_addr;
    logic [31:0] mem_wdata;
    logic        mem_ack;
    logic [31:0] mem_rdata;
    logic        busy;
    logic        done;

    span_entry_t spans [NUM_SPANS];
    logic [31:0] sigs [NUM_SPANS];
    logic [31:0] memory [addr_t];
    logic        stall_en;
    int          tb_errors = 0;
    int          sb_errors;

    span_zbuf_top i_span_zbuf_top (
        .rd_req     (rd_req),
        .arst_n     (arst_n),
        .start      (start),
        .fb_addr    (fb_addr),
        .zbuff_addr (zbuff_addr),
        .dx         (dx),
        .z1         (z1),
        .slope      (slope),
        .rem        (rem),
        .err        (err),
        .rgbx       (rgbx),
        .mem_rd     (mem_rd),
        .mem_wr     (mem_wr),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_ack    (mem_ack),
        .mem_rdata  (mem_rdata),
        .busy       (busy),
        .done       (done)
    );

    span_zbuf_scoreboard i_scoreboard (
        .rd_req     (rd_req),
        .arst_n     (arst_n),
        .start      (start),
        .busy       (busy),
        .done       (done),
        .fb_addr    (fb_addr),
        .zbuff_addr (zbuff_addr),
        .dx         (dx),
        .z1         (z1),
        .slope      (slope),
        .rem        (rem),
        .err        (err),
        .rgbx       (rgbx),
        .mem_rd     (mem_rd),
        .mem_wr     (mem_wr),
        .mem_ack    (mem_ack),
        .mem_addr   (mem_addr),
        .mem_rdata  (mem_rdata),
        .mem_wdata  (mem_wdata),
        .errors     (sb_errors)
    );

    initial
    begin
        rd_req = 1'b0;
        forever
        begin
            #5 rd_req = ~rd_req;
        end
    end

    // columns: dx, z1, slope, rem, err, rgbx, fb, zb,
    // zpat, stall, busy_start, expected write beats, reference span
    task automatic load_span_table();
        spans[0] = '{32'd8, 32'h0000_1000, 32'h0000_0100, 32'd0, 32'd0, 32'h11AA_22FF,
                     32'h1000_0000, 32'h2000_0000, 2'd0, 1'b0, 1'b0, 8'd16, 8'hFF};
        spans[1] = '{32'd21, 32'h4000_0000, 32'h0100_0000, 32'd7, 32'd3, 32'h3355_77FF,
                     32'h1000_1000, 32'h2000_1000, 2'd0, 1'b0, 1'b0, 8'd42, 8'hFF};
        spans[2] = '{32'd19, 32'h6000_0000, 32'h0200_0000, 32'd5, 32'd0, 32'h0A0B_0CFF,
                     32'h1000_2000, 32'h2000_2000, 2'd2, 1'b0, 1'b0, 8'd38, 8'hFF};
        spans[3] = '{32'd21, 32'h4000_0000, 32'h0100_0000, 32'd7, 32'd3, 32'h3355_77FF,
                     32'h1000_1000, 32'h2000_1000, 2'd0, 1'b1, 1'b0, 8'd42, 8'd1};
        spans[4] = '{32'd19, 32'h6000_0000, 32'h0200_0000, 32'd5, 32'd0, 32'h0A0B_0CFF,
                     32'h1000_2000, 32'h2000_2000, 2'd2, 1'b1, 1'b0, 8'd38, 8'd2};
        // z wraps past zero mid span
        spans[5] = '{32'd12, 32'hFFFF_FF00, 32'h0000_0040, 32'd11, 32'd2, 32'hDEAD_00FF,
                     32'h1000_3000, 32'h2000_3000, 2'd2, 1'b1, 1'b1, 8'd24, 8'hFF};
        spans[6] = '{32'd3, 32'h7000_0000, 32'h0000_0010, 32'd1, 32'd0, 32'h5566_77FF,
                     32'h1000_4000, 32'h2000_4000, 2'd1, 1'b1, 1'b0, 8'd6, 8'hFF};
    endtask

    // 0 lets every pixel pass, 1 lets none pass, 2 mixes
    function automatic logic [31:0] stored_depth(logic [1:0] pat, addr_t a);
        case (pat)
            2'd0:    return 32'hFFFF_FFFF;
            2'd1:    return 32'h0000_0000;
            default: return a * 32'h9E37_79B9;
        endcase
    endfunction

    // colour words come from the fill
    function automatic logic [31:0] read_word(addr_t a);
        if (memory.exists(a))
        begin
            return memory[a];
        end
        return {a[15:0], a[31:16]} ^ 32'h00C3_A55A;
    endfunction

    function automatic int total_errors();
        return tb_errors + sb_errors + i_span_zbuf_top.i_span_ctrl.i_span_zbuf_chk.fail_cnt;
    endfunction

    task automatic note_error(string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        tb_errors++;
    endtask

    // memory model, about one stall cycle in four when enabled
    always @(posedge rd_req)
    begin
        #1;
        mem_ack   = stall_en ? ($urandom_range(3) != 0) : 1'b1;
        mem_rdata = read_word(mem_addr);
    end

    always @(negedge rd_req)
    begin
        if (mem_wr && mem_ack)
        begin
            memory[mem_addr] = mem_wdata;
        end
    end

    initial
    begin
        span_entry_t ent;
        int          k;
        int          i;
        int          cyc;
        int          wr_beats;
        int          errs_before;
        int          passed;
        int          limit;
        logic        done_seen;
        logic [31:0] sig;

        void'($urandom(98828));
        arst_n     = 1'b0;
        start      = 1'b0;
        fb_addr    = '0;
        zbuff_addr = '0;
        dx         = '0;
        z1         = '0;
        slope      = '0;
        rem        = '0;
        err        = '0;
        rgbx       = '0;
        mem_ack    = 1'b0;
        mem_rdata  = '0;
        stall_en   = 1'b0;
        passed     = 0;
        load_span_table();

        limit = 10;
        for (k = 0; k < NUM_SPANS; k++)
        begin
            limit = limit + 40 * int'(spans[k].dx) + 200;
        end
        fork
            begin
                #(limit * 10);
                $display("Watchdog timeout: the run did not finish within %0d cycles", limit);
                $display("Some tests failed");
                $finish;
            end
        join_none

        repeat (10) @(posedge rd_req);
        #1;
        arst_n = 1'b1;

        for (k = 0; k < NUM_SPANS; k++)
        begin
            ent         = spans[k];
            errs_before = total_errors();
            memory.delete();
            for (i = 0; i < int'(ent.dx); i++)
            begin
                memory[ent.zb + addr_t'(i * `SPAN_WORD_BYTES)] =
                    stored_depth(ent.zpat, ent.zb + addr_t'(i * `SPAN_WORD_BYTES));
            end
            stall_en = ent.stall;

            @(posedge rd_req);
            #1;
            fb_addr    = ent.fb;
            zbuff_addr = ent.zb;
            dx         = ent.dx;
            z1         = ent.z1;
            slope      = ent.slope;
            rem        = ent.rem;
            err        = ent.err;
            rgbx       = ent.rgbx;
            start      = 1'b1;
            @(posedge rd_req);
            #1;
            start = 1'b0;

            cyc       = 0;
            wr_beats  = 0;
            sig       = '0;
            done_seen = 1'b0;
            while (!done_seen)
            begin
                @(negedge rd_req);
                if (mem_wr && mem_ack)
                begin
                    wr_beats++;
                    sig = sig * 32'd31 + (mem_wdata ^ mem_addr);
                end
                done_seen = done;
                @(posedge rd_req);
                #1;
                // stray start in the middle of the span
                start = ent.busy_start && (cyc == 5);
                cyc++;
            end
            start = 1'b0;

            repeat (4)
            begin
                @(negedge rd_req);
                if (done || busy || mem_rd || mem_wr)
                begin
                    note_error($sformatf("span %0d: engine active after done", k));
                end
            end

            sigs[k] = sig;
            if (wr_beats != int'(ent.exp_beats))
            begin
                note_error($sformatf("span %0d: %0d write beats, expected %0d",
                                     k, wr_beats, ent.exp_beats));
            end
            if (ent.ref_idx != 8'hFF && sig !== sigs[ent.ref_idx])
            begin
                note_error($sformatf("span %0d: write data differs from span %0d",
                                     k, ent.ref_idx));
            end
            if (total_errors() == errs_before)
            begin
                passed++;
            end
            $display("span %0d: dx=%0d stall=%0d cycles=%0d %s", k, ent.dx, ent.stall, cyc,
                     (total_errors() == errs_before) ? "ok" : "FAILED");
        end

        $display("spans run: %0d, passed: %0d, failed: %0d, errors: %0d",
                 NUM_SPANS, passed, NUM_SPANS - passed, total_errors());
        if (total_errors() == 0)
        begin
            $display("All tests passed");
        end
        else
        begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: span_zbuf.f
+incdir+design
design/span_zbuf_pkg.sv
design/span_fifo.sv
design/span_interp.sv
design/depth_merge.sv
design/span_ctrl.sv
design/span_zbuf_top.sv
tests/span_zbuf_scoreboard.sv
tests/span_zbuf_chk.sv
tests/span_zbuf_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the span_zbuf testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f span_zbuf.f --top-module span_zbuf_tb -Mdir obj_dir

# a stopped simulation still has its output searched
out=$(./obj_dir/Vspan_zbuf_tb 2>&1) || true
echo "$out"

if echo "$out" | grep -q "All tests passed"; then
    exit 0
fi
exit 1
